//--- src/cw_reg_pkg.sv
package cw_reg_pkg;

	// Register bus widths
	localparam int REG_ADDR_W = 6;
	localparam int REG_DATA_W = 8;
	localparam int REG_BCNT_W = 8;

	// Register map
	// Trigger config: [3:0] IO mask, [4] mode (0 = OR, 1 = AND)
	localparam logic [REG_ADDR_W-1:0] REG_TRIG_CFG = REG_ADDR_W'(1);

	// Glitch offset is two bytes, low byte at byte count 0
	localparam logic [REG_ADDR_W-1:0] REG_GLITCH_OFFSET = REG_ADDR_W'(2);
	localparam logic [REG_ADDR_W-1:0] REG_GLITCH_WIDTH = REG_ADDR_W'(3);

	// Target control: [0] AVR programming enable, [1] target power off
	localparam logic [REG_ADDR_W-1:0] REG_TARGET_CTRL = REG_ADDR_W'(4);

endpackage

//--- src/cw_target_pkg.sv
package cw_target_pkg;

	// Target IO lines feeding the trigger
	localparam int NUM_TRIG_IO = 4;

	// Flops per line in the IO synchronizer
	localparam int SYNC_STAGES = 2;

	// Glitch generator counters
	localparam int GLITCH_OFS_W = 16;
	localparam int GLITCH_WIDTH_W = 8;

endpackage

//--- src/usb_reg_bridge.sv
`timescale 1ns/1ns

module usb_reg_bridge import cw_reg_pkg::*; (
	input  logic                  clk_usb,
	input  logic                  rst_n_i,

	// USB parallel bus, strobes active low
	input  logic [REG_ADDR_W-1:0] usb_addr_i,
	input  logic [REG_DATA_W-1:0] usb_data_i,
	input  logic                  usb_aleN_i,
	input  logic                  usb_cen_i,
	input  logic                  usb_wrn_i,
	input  logic                  usb_rdn_i,
	output logic [REG_DATA_W-1:0] usb_data_o,
	output logic                  usb_data_oe_o,

	// Register bus
	output logic [REG_ADDR_W-1:0] reg_addr_o,
	output logic [REG_BCNT_W-1:0] reg_bcnt_o,
	output logic [REG_DATA_W-1:0] reg_wdata_o,
	output logic                  reg_write_o,
	output logic                  reg_read_o,
	input  logic [REG_DATA_W-1:0] reg_rdata_trig_i,
	input  logic [REG_DATA_W-1:0] reg_rdata_glitch_i,
	input  logic [REG_DATA_W-1:0] reg_rdata_target_i
);

	logic [REG_ADDR_W-1:0] addr_q;
	logic [REG_DATA_W-1:0] data_q;
	logic                  ale_n_q;
	logic                  cen_q;
	logic                  wrn_q;
	logic                  rdn_q;
	logic                  wr_sel;
	logic                  rd_sel;
	logic                  wr_sel_d;
	logic                  rd_sel_d;
	logic                  wr_start;
	logic                  xfer_done;
	logic [REG_DATA_W-1:0] rdata_or;
	logic [REG_DATA_W-1:0] rdata_q;

	// Bus sampling, strobes idle high
	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ale_n_q <= 1'b1;
			cen_q   <= 1'b1;
			wrn_q   <= 1'b1;
			rdn_q   <= 1'b1;
		end else begin
			ale_n_q <= usb_aleN_i;
			cen_q   <= usb_cen_i;
			wrn_q   <= usb_wrn_i;
			rdn_q   <= usb_rdn_i;
		end
	end

	always_ff @(posedge clk_usb) begin
		addr_q <= usb_addr_i;
		data_q <= usb_data_i;
	end

	assign wr_sel = !cen_q && !wrn_q;
	assign rd_sel = !cen_q && !rdn_q;
	assign wr_start = wr_sel && !wr_sel_d; // First cycle of a write
	assign xfer_done = (wr_sel_d && !wr_sel) || (rd_sel_d && !rd_sel);

	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_sel_d      <= 1'b0;
			rd_sel_d      <= 1'b0;
			reg_write_o   <= 1'b0;
			reg_read_o    <= 1'b0;
			usb_data_oe_o <= 1'b0;
			reg_addr_o    <= '0;
			reg_bcnt_o    <= '0;
		end else begin
			wr_sel_d      <= wr_sel;
			rd_sel_d      <= rd_sel;
			reg_write_o   <= wr_start;
			reg_read_o    <= rd_sel && !rd_sel_d;
			usb_data_oe_o <= rd_sel; // Drive bus only during a read
			if (!ale_n_q) begin
				reg_addr_o <= addr_q;
				reg_bcnt_o <= '0; // New address restarts the byte count
			end else if (xfer_done) begin
				reg_bcnt_o <= reg_bcnt_o + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_usb) begin
		if (wr_start) reg_wdata_o <= data_q;
	end

	// Blocks return zero when not addressed
	assign rdata_or = reg_rdata_trig_i | reg_rdata_glitch_i | reg_rdata_target_i;

	always_ff @(posedge clk_usb) begin
		if (reg_read_o) rdata_q <= rdata_or; // Held until the next read
		usb_data_o <= rdata_q;
	end

endmodule

//--- src/reg_trigger.sv
`timescale 1ns/1ns

module reg_trigger import cw_reg_pkg::*, cw_target_pkg::*; (
	input  logic                   clk_usb,
	input  logic                   rst_n_i,
	input  logic [REG_ADDR_W-1:0]  reg_addr_i,
	input  logic [REG_BCNT_W-1:0]  reg_bcnt_i,
	input  logic [REG_DATA_W-1:0]  reg_wdata_i,
	input  logic                   reg_write_i,
	output logic [REG_DATA_W-1:0]  reg_rdata_o,
	input  logic [NUM_TRIG_IO-1:0] target_io_i,
	output logic                   trigger_o
);

	logic                   cfg_sel;
	logic [NUM_TRIG_IO:0]   cfg_q; // Mask plus mode bit
	logic [NUM_TRIG_IO-1:0] io_mask;
	logic                   mode_and;
	logic [NUM_TRIG_IO-1:0] sync_q [SYNC_STAGES];
	logic [NUM_TRIG_IO-1:0] io_masked;
	logic                   trig_next;

	assign cfg_sel = (reg_addr_i == REG_TRIG_CFG) && (reg_bcnt_i == '0);
	assign io_mask = cfg_q[NUM_TRIG_IO-1:0];
	assign mode_and = cfg_q[NUM_TRIG_IO];

	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cfg_q <= '0;
		end else if (reg_write_i && cfg_sel) begin
			cfg_q <= reg_wdata_i[NUM_TRIG_IO:0];
		end
	end

	assign reg_rdata_o = cfg_sel ? {{(REG_DATA_W-NUM_TRIG_IO-1){1'b0}}, cfg_q} : '0;

	// IO synchronizer chain
	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < SYNC_STAGES; i++) sync_q[i] <= '0;
		end else begin
			sync_q[0] <= target_io_i;
			for (int i = 1; i < SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];
		end
	end

	assign io_masked = sync_q[SYNC_STAGES-1] & io_mask;

	always_comb begin
		if (mode_and)
			trig_next = (io_masked == io_mask) && (io_mask != '0); // Empty mask never fires
		else
			trig_next = |io_masked;
	end

	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) trigger_o <= 1'b0;
		else trigger_o <= trig_next;
	end

endmodule

//--- src/reg_glitch.sv
`timescale 1ns/1ns

module reg_glitch import cw_reg_pkg::*, cw_target_pkg::*; (
	input  logic                  clk_usb,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] reg_addr_i,
	input  logic [REG_BCNT_W-1:0] reg_bcnt_i,
	input  logic [REG_DATA_W-1:0] reg_wdata_i,
	input  logic                  reg_write_i,
	output logic [REG_DATA_W-1:0] reg_rdata_o,
	input  logic                  trigger_i,
	output logic                  glitch_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DELAY,
		ST_PULSE,
		ST_WAIT_REL
	} state_t;

	state_t                    state;
	logic                      ofs_lo_sel;
	logic                      ofs_hi_sel;
	logic                      width_sel;
	logic [GLITCH_OFS_W-1:0]   ofs_q;
	logic [GLITCH_WIDTH_W-1:0] width_q;
	logic [GLITCH_OFS_W-1:0]   ofs_cnt;
	logic [GLITCH_WIDTH_W-1:0] wid_cnt;
	logic                      fire;

	assign ofs_lo_sel = (reg_addr_i == REG_GLITCH_OFFSET) && (reg_bcnt_i == '0);
	assign ofs_hi_sel = (reg_addr_i == REG_GLITCH_OFFSET) && (reg_bcnt_i == REG_BCNT_W'(1));
	assign width_sel = (reg_addr_i == REG_GLITCH_WIDTH) && (reg_bcnt_i == '0);

	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ofs_q   <= '0;
			width_q <= '0;
		end else if (reg_write_i) begin
			if (ofs_lo_sel) ofs_q[REG_DATA_W-1:0] <= reg_wdata_i;
			if (ofs_hi_sel) ofs_q[REG_DATA_W +: REG_DATA_W] <= reg_wdata_i;
			if (width_sel) width_q <= reg_wdata_i;
		end
	end

	always_comb begin
		reg_rdata_o = '0;
		if (ofs_lo_sel) reg_rdata_o = ofs_q[REG_DATA_W-1:0];
		else if (ofs_hi_sel) reg_rdata_o = ofs_q[REG_DATA_W +: REG_DATA_W];
		else if (width_sel) reg_rdata_o = width_q;
	end

	// Offset reached, zero offset fires straight from idle
	assign fire = ((state == ST_IDLE) && trigger_i && (ofs_q == '0)) ||
		((state == ST_DELAY) && (ofs_cnt == ofs_q));

	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= ST_IDLE;
			ofs_cnt  <= '0;
			wid_cnt  <= '0;
			glitch_o <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (trigger_i) begin
						ofs_cnt <= GLITCH_OFS_W'(1);
						state   <= ST_DELAY;
					end
				end
				ST_DELAY: ofs_cnt <= ofs_cnt + 1'b1;
				ST_PULSE: begin
					if (wid_cnt == width_q) begin
						glitch_o <= 1'b0;
						state    <= ST_WAIT_REL;
					end else begin
						wid_cnt <= wid_cnt + 1'b1;
					end
				end
				ST_WAIT_REL: if (!trigger_i) state <= ST_IDLE; // Rearm
				default: state <= ST_IDLE;
			endcase
			if (fire) begin
				if (width_q != '0) begin
					wid_cnt  <= GLITCH_WIDTH_W'(1);
					glitch_o <= 1'b1;
					state    <= ST_PULSE;
				end else begin
					state <= ST_WAIT_REL; // Zero width, no pulse
				end
			end
		end
	end

endmodule

//--- src/reg_target_io.sv
`timescale 1ns/1ns

module reg_target_io import cw_reg_pkg::*; (
	input  logic                  clk_usb,
	input  logic                  rst_n_i,
	input  logic [REG_ADDR_W-1:0] reg_addr_i,
	input  logic [REG_BCNT_W-1:0] reg_bcnt_i,
	input  logic [REG_DATA_W-1:0] reg_wdata_i,
	input  logic                  reg_write_i,
	output logic [REG_DATA_W-1:0] reg_rdata_o,

	// SPI and reset from the USB controller
	input  logic                  usb_spi_sck_i,
	input  logic                  usb_spi_mosi_i,
	input  logic                  usb_treset_i,
	output logic                  usb_spi_miso_o,

	// Target side
	input  logic                  target_miso_i,
	input  logic                  ext_miso_i,
	output logic                  target_sck_o,
	output logic                  target_mosi_o,
	output logic                  target_nrst_o,
	output logic                  target_prog_oe_o,
	output logic                  target_npower_o
);

	logic       ctrl_sel;
	logic [1:0] ctrl_q;
	logic       prog_en;

	assign ctrl_sel = (reg_addr_i == REG_TARGET_CTRL) && (reg_bcnt_i == '0);

	always_ff @(posedge clk_usb or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_q <= '0;
		end else if (reg_write_i && ctrl_sel) begin
			ctrl_q <= reg_wdata_i[1:0];
		end
	end

	assign reg_rdata_o = ctrl_sel ? {{(REG_DATA_W-2){1'b0}}, ctrl_q} : '0;

	assign prog_en = ctrl_q[0]; // AVR programming passthrough

	// Pins released to the target when not programming
	assign target_prog_oe_o = prog_en;
	assign target_sck_o = prog_en ? usb_spi_sck_i : 1'b0;
	assign target_mosi_o = prog_en ? usb_spi_mosi_i : 1'b0;
	assign target_nrst_o = prog_en ? usb_treset_i : 1'b0;

	// MISO from target while programming, else external header
	assign usb_spi_miso_o = prog_en ? target_miso_i : ext_miso_i;

	assign target_npower_o = ctrl_q[1];

endmodule

//--- src/cw_lite_top.sv
`timescale 1ns/1ns

module cw_lite_top import cw_reg_pkg::*, cw_target_pkg::*; (
	input  logic                   clk_usb,
	input  logic                   rst_n_i,

	// USB parallel bus
	input  logic [REG_ADDR_W-1:0]  usb_addr_i,
	input  logic [REG_DATA_W-1:0]  usb_data_i,
	input  logic                   usb_aleN_i,
	input  logic                   usb_cen_i,
	input  logic                   usb_wrn_i,
	input  logic                   usb_rdn_i,
	output logic [REG_DATA_W-1:0]  usb_data_o,
	output logic                   usb_data_oe_o,

	// Trigger and glitch
	input  logic [NUM_TRIG_IO-1:0] target_io_i,
	output logic                   trigger_o,
	output logic                   glitch_o,

	// AVR programming and power
	input  logic                   usb_spi_sck_i,
	input  logic                   usb_spi_mosi_i,
	input  logic                   usb_treset_i,
	output logic                   usb_spi_miso_o,
	input  logic                   target_miso_i,
	input  logic                   ext_miso_i,
	output logic                   target_sck_o,
	output logic                   target_mosi_o,
	output logic                   target_nrst_o,
	output logic                   target_prog_oe_o,
	output logic                   target_npower_o
);

	logic [REG_ADDR_W-1:0] reg_addr;
	logic [REG_BCNT_W-1:0] reg_bcnt;
	logic [REG_DATA_W-1:0] reg_wdata;
	logic                  reg_write;
	logic [REG_DATA_W-1:0] reg_rdata_trig;
	logic [REG_DATA_W-1:0] reg_rdata_glitch;
	logic [REG_DATA_W-1:0] reg_rdata_target;

	usb_reg_bridge usb_reg_bridge_inst (
		.clk_usb(clk_usb),
		.rst_n_i(rst_n_i),
		.usb_addr_i(usb_addr_i),
		.usb_data_i(usb_data_i),
		.usb_aleN_i(usb_aleN_i),
		.usb_cen_i(usb_cen_i),
		.usb_wrn_i(usb_wrn_i),
		.usb_rdn_i(usb_rdn_i),
		.usb_data_o(usb_data_o),
		.usb_data_oe_o(usb_data_oe_o),
		.reg_addr_o(reg_addr),
		.reg_bcnt_o(reg_bcnt),
		.reg_wdata_o(reg_wdata),
		.reg_write_o(reg_write),
		.reg_read_o(), // Blocks return data combinationally, no read side effects
		.reg_rdata_trig_i(reg_rdata_trig),
		.reg_rdata_glitch_i(reg_rdata_glitch),
		.reg_rdata_target_i(reg_rdata_target)
	);

	reg_trigger reg_trigger_inst (
		.clk_usb(clk_usb),
		.rst_n_i(rst_n_i),
		.reg_addr_i(reg_addr),
		.reg_bcnt_i(reg_bcnt),
		.reg_wdata_i(reg_wdata),
		.reg_write_i(reg_write),
		.reg_rdata_o(reg_rdata_trig),
		.target_io_i(target_io_i),
		.trigger_o(trigger_o)
	);

	reg_glitch reg_glitch_inst (
		.clk_usb(clk_usb),
		.rst_n_i(rst_n_i),
		.reg_addr_i(reg_addr),
		.reg_bcnt_i(reg_bcnt),
		.reg_wdata_i(reg_wdata),
		.reg_write_i(reg_write),
		.reg_rdata_o(reg_rdata_glitch),
		.trigger_i(trigger_o),
		.glitch_o(glitch_o)
	);

	reg_target_io reg_target_io_inst (
		.clk_usb(clk_usb),
		.rst_n_i(rst_n_i),
		.reg_addr_i(reg_addr),
		.reg_bcnt_i(reg_bcnt),
		.reg_wdata_i(reg_wdata),
		.reg_write_i(reg_write),
		.reg_rdata_o(reg_rdata_target),
		.usb_spi_sck_i(usb_spi_sck_i),
		.usb_spi_mosi_i(usb_spi_mosi_i),
		.usb_treset_i(usb_treset_i),
		.usb_spi_miso_o(usb_spi_miso_o),
		.target_miso_i(target_miso_i),
		.ext_miso_i(ext_miso_i),
		.target_sck_o(target_sck_o),
		.target_mosi_o(target_mosi_o),
		.target_nrst_o(target_nrst_o),
		.target_prog_oe_o(target_prog_oe_o),
		.target_npower_o(target_npower_o)
	);

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // 20 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		#2 rst_n_o = 1'b1;
	end

endmodule

//--- test/cw_lite_tb.sv
`timescale 1ns/1ns

module cw_lite_tb import cw_reg_pkg::*, cw_target_pkg::*; ();

	logic                   clk_usb;
	logic                   rst_n;
	logic [REG_ADDR_W-1:0]  usb_addr;
	logic [REG_DATA_W-1:0]  usb_wdata;
	logic                   usb_ale_n;
	logic                   usb_ce_n;
	logic                   usb_wr_n;
	logic                   usb_rd_n;
	logic [REG_DATA_W-1:0]  usb_rdata;
	logic                   usb_rdata_oe;
	logic [NUM_TRIG_IO-1:0] target_io;
	logic                   trigger;
	logic                   glitch;
	logic                   spi_sck;
	logic                   spi_mosi;
	logic                   treset;
	logic                   spi_miso;
	logic                   target_miso;
	logic                   ext_miso;
	logic                   target_sck;
	logic                   target_mosi;
	logic                   target_nrst;
	logic                   prog_oe;
	logic                   npower;

	integer seed = 39;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int checks_done = 0;
	logic [15:0] got_q [$];
	logic [15:0] want_q [$];
	string what_q [$];

	// Register model
	logic [REG_DATA_W-1:0]   trig_cfg_m;
	logic [GLITCH_OFS_W-1:0] ofs_m;
	logic [REG_DATA_W-1:0]   width_m;
	logic [REG_DATA_W-1:0]   ctrl_m;

	tb_clock_gen clock_gen_inst (.clk_o(clk_usb), .rst_n_o(rst_n));

	cw_lite_top cw_lite_top_inst (
		.clk_usb(clk_usb),
		.rst_n_i(rst_n),
		.usb_addr_i(usb_addr),
		.usb_data_i(usb_wdata),
		.usb_aleN_i(usb_ale_n),
		.usb_cen_i(usb_ce_n),
		.usb_wrn_i(usb_wr_n),
		.usb_rdn_i(usb_rd_n),
		.usb_data_o(usb_rdata),
		.usb_data_oe_o(usb_rdata_oe),
		.target_io_i(target_io),
		.trigger_o(trigger),
		.glitch_o(glitch),
		.usb_spi_sck_i(spi_sck),
		.usb_spi_mosi_i(spi_mosi),
		.usb_treset_i(treset),
		.usb_spi_miso_o(spi_miso),
		.target_miso_i(target_miso),
		.ext_miso_i(ext_miso),
		.target_sck_o(target_sck),
		.target_mosi_o(target_mosi),
		.target_nrst_o(target_nrst),
		.target_prog_oe_o(prog_oe),
		.target_npower_o(npower)
	);

	// Readback value of one register byte
	function automatic logic [REG_DATA_W-1:0] expected_read(input logic [REG_ADDR_W-1:0] addr,
		input int bcnt);
		logic [REG_DATA_W-1:0] val;
		val = '0;
		if (addr == REG_TRIG_CFG && bcnt == 0)
			val = trig_cfg_m & REG_DATA_W'((1 << (NUM_TRIG_IO + 1)) - 1); // Mask plus mode
		else if (addr == REG_GLITCH_OFFSET && bcnt < 2)
			val = REG_DATA_W'(ofs_m >> (REG_DATA_W * bcnt));
		else if (addr == REG_GLITCH_WIDTH && bcnt == 0)
			val = width_m;
		else if (addr == REG_TARGET_CTRL && bcnt == 0)
			val = ctrl_m & REG_DATA_W'(3);
		return val;
	endfunction

	function automatic logic expected_trigger(input logic [REG_DATA_W-1:0] cfg,
		input logic [NUM_TRIG_IO-1:0] io);
		logic [NUM_TRIG_IO-1:0] mask;
		mask = cfg[NUM_TRIG_IO-1:0];
		if (mask == '0) return 1'b0;
		if (cfg[NUM_TRIG_IO]) return (io & mask) == mask; // AND mode
		return |(io & mask);
	endfunction

	// Cycles from the first trigger cycle to the glitch edge
	function automatic int glitch_delay(input int ofs);
		return ofs + 1;
	endfunction

	// {prog_oe, miso, npower}
	function automatic logic [2:0] expected_routing(input logic [1:0] ctrl, input logic tmiso,
		input logic emiso);
		logic miso;
		miso = ctrl[0] ? tmiso : emiso; // Target MISO only while programming
		return {ctrl[0], miso, ctrl[1]};
	endfunction

	// Compare process, drains pending checks on each falling edge
	always @(negedge clk_usb) begin : compare
		logic [15:0] got;
		logic [15:0] want;
		string what;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			want = want_q.pop_front();
			what = what_q.pop_front();
			checks_done++;
			assert (got === want) else begin
				$display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
				test_errors++;
			end
		end
	end

	task automatic step_cycle();
		@(posedge clk_usb);
		#2;
	endtask

	task automatic expect_value(input string what, input logic [15:0] got,
		input logic [15:0] want);
		got_q.push_back(got);
		want_q.push_back(want);
		what_q.push_back(what);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		test_errors++;
	endtask

	task automatic set_address(input logic [REG_ADDR_W-1:0] addr);
		usb_addr = addr;
		usb_ale_n = 1'b0;
		step_cycle();
		usb_ale_n = 1'b1;
		step_cycle();
	endtask

	task automatic write_byte(input logic [REG_DATA_W-1:0] data);
		usb_wdata = data;
		usb_ce_n = 1'b0;
		usb_wr_n = 1'b0;
		step_cycle();
		usb_ce_n = 1'b1;
		usb_wr_n = 1'b1;
		repeat (3) step_cycle(); // Register update and byte count step
	endtask

	task automatic read_byte(output logic [REG_DATA_W-1:0] data);
		bit seen;
		seen = 0;
		usb_ce_n = 1'b0;
		usb_rd_n = 1'b0;
		for (int n = 0; n < 8 && !seen; n++) begin
			step_cycle();
			seen = usb_rdata_oe;
		end
		assert (seen) else report_timeout("usb_data_oe_o never went high during a read");
		repeat (2) step_cycle(); // Data valid 3 cycles after RDn sampled low
		data = usb_rdata;
		usb_ce_n = 1'b1;
		usb_rd_n = 1'b1;
		repeat (3) step_cycle();
		expect_value("usb_data_oe_o after read", usb_rdata_oe, 0);
	endtask

	task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [15:0] value,
		input int nbytes);
		set_address(addr);
		for (int i = 0; i < nbytes; i++) write_byte(value[i*8 +: 8]);
		case (addr)
			REG_TRIG_CFG: trig_cfg_m = value[7:0];
			REG_GLITCH_OFFSET: ofs_m = value;
			REG_GLITCH_WIDTH: width_m = value[7:0];
			REG_TARGET_CTRL: ctrl_m = value[7:0];
			default: ;
		endcase
	endtask

	task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input int nbytes);
		logic [REG_DATA_W-1:0] data;
		set_address(addr);
		for (int i = 0; i < nbytes; i++) begin
			read_byte(data);
			expect_value($sformatf("read of address %0d byte %0d", addr, i), data,
				expected_read(addr, i));
		end
	endtask

	task automatic finish_test(input string name);
		bit drained;
		drained = 0;
		for (int n = 0; n < 4 && !drained; n++) begin
			@(posedge clk_usb);
			drained = (got_q.size() == 0);
		end
		assert (drained) else report_timeout("pending checks were never compared");
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d %s: PASS", tests_run, name);
		end else begin
			$display("Test %0d %s: FAIL with %0d errors", tests_run, name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
		#2; // Back to the drive point
	endtask

	initial begin : stimulus
		logic [REG_DATA_W-1:0]  cfg;
		logic [NUM_TRIG_IO-1:0] io;
		logic [4:0]             pins;
		int                     ofs;
		int                     width;
		int                     bit_sel;
		int                     dly;
		int                     len;
		bit                     seen;

		usb_addr = '0;
		usb_wdata = '0;
		usb_ale_n = 1'b1;
		usb_ce_n = 1'b1;
		usb_wr_n = 1'b1;
		usb_rd_n = 1'b1;
		target_io = '0;
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		treset = 1'b0;
		target_miso = 1'b0;
		ext_miso = 1'b0;
		trig_cfg_m = '0;
		ofs_m = '0;
		width_m = '0;
		ctrl_m = '0;

		for (int n = 0; n < 20 && !rst_n; n++) @(posedge clk_usb);
		assert (rst_n) else report_timeout("reset was never released");
		step_cycle();

		// Reset state
		expect_value("glitch_o after reset", glitch, 0);
		expect_value("trigger_o after reset", trigger, 0);
		expect_value("usb_data_oe_o after reset", usb_rdata_oe, 0);
		expect_value("target_prog_oe_o after reset", prog_oe, 0);
		expect_value("target_npower_o after reset", npower, 0);
		check_reg(REG_TRIG_CFG, 1);
		check_reg(REG_GLITCH_OFFSET, 2);
		check_reg(REG_GLITCH_WIDTH, 1);
		check_reg(REG_TARGET_CTRL, 1);
		finish_test("reset state");

		// Register readback
		write_reg(REG_TRIG_CFG, 16'($random(seed)), 1);
		write_reg(REG_GLITCH_OFFSET, 16'($random(seed)), 2);
		write_reg(REG_GLITCH_WIDTH, 16'($random(seed)), 1);
		write_reg(REG_TARGET_CTRL, 16'($random(seed)), 1);
		check_reg(REG_TRIG_CFG, 1);
		check_reg(REG_GLITCH_OFFSET, 2);
		check_reg(REG_GLITCH_WIDTH, 1);
		check_reg(REG_TARGET_CTRL, 1);
		check_reg(REG_ADDR_W'(0), 1);
		check_reg(REG_ADDR_W'(5 + $unsigned($random(seed)) % 59), 1); // Unmapped
		write_reg(REG_GLITCH_OFFSET, 16'(0), 2); // Short glitch delay for the trigger test
		write_reg(REG_GLITCH_WIDTH, 16'(0), 1);
		write_reg(REG_TARGET_CTRL, 16'(0), 1);
		finish_test("register readback");

		// Trigger logic
		for (int i = 0; i < 24; i++) begin
			cfg = REG_DATA_W'($random(seed)) & REG_DATA_W'(8'h1f);
			if (i < 2) cfg = REG_DATA_W'(i << NUM_TRIG_IO); // Empty mask in both modes
			io = NUM_TRIG_IO'($random(seed));
			write_reg(REG_TRIG_CFG, 16'(cfg), 1);
			target_io = io;
			repeat (5) step_cycle();
			expect_value($sformatf("trigger_o for cfg 0x%0h io 0x%0h", cfg, io), trigger,
				expected_trigger(cfg, io));
		end
		target_io = '0;
		finish_test("trigger logic");

		// Glitch timing
		for (int i = 0; i < 10; i++) begin
			ofs = (i == 0) ? 0 : $unsigned($random(seed)) % 41;
			width = (i == 1) ? 0 : $unsigned($random(seed)) % 21;
			bit_sel = $unsigned($random(seed)) % NUM_TRIG_IO;
			target_io = '0;
			seen = 0;
			for (int n = 0; n < 10 && !seen; n++) begin
				step_cycle();
				seen = !trigger;
			end
			assert (seen) else report_timeout("trigger_o did not fall before a glitch run");
			repeat (3) step_cycle(); // Glitch FSM back to idle
			write_reg(REG_TRIG_CFG, 16'(1 << bit_sel), 1);
			write_reg(REG_GLITCH_OFFSET, 16'(ofs), 2);
			write_reg(REG_GLITCH_WIDTH, 16'(width), 1);
			target_io[bit_sel] = 1'b1;
			seen = 0;
			for (int n = 0; n < 10 && !seen; n++) begin
				step_cycle();
				seen = trigger;
			end
			assert (seen) else report_timeout("trigger_o did not rise for a glitch run");
			expect_value("glitch_o in the first trigger cycle", glitch, 0);
			seen = 0;
			dly = 0;
			for (int n = 0; n < 60 && !seen; n++) begin
				step_cycle();
				dly++;
				seen = glitch;
			end
			if (width == 0) begin
				expect_value("glitch pulse for zero width", seen, 0);
			end else begin
				assert (seen) else report_timeout("glitch_o did not rise within 60 cycles");
				expect_value($sformatf("glitch delay for offset %0d", ofs), dly,
					glitch_delay(ofs));
				len = 1;
				for (int n = 0; n < 40 && glitch; n++) begin
					step_cycle();
					if (glitch) len++;
				end
				assert (!glitch) else report_timeout("glitch_o did not fall within 40 cycles");
				expect_value($sformatf("glitch length for width %0d", width), len, width);
			end
		end
		target_io = '0;
		finish_test("glitch timing");

		// Target routing
		for (int c = 0; c < 4; c++) begin
			write_reg(REG_TARGET_CTRL, 16'(c), 1);
			for (int k = 0; k < 4; k++) begin
				pins = 5'($random(seed));
				{spi_sck, spi_mosi, treset, target_miso, ext_miso} = pins;
				#1;
				expect_value($sformatf("oe/miso/npower for ctrl %0d pins 0x%0h", c, pins),
					{prog_oe, spi_miso, npower}, expected_routing(2'(c), pins[1], pins[0]));
				if ((c % 2) == 1) begin
					expect_value($sformatf("sck/mosi/nrst passthrough pins 0x%0h", pins),
						{target_sck, target_mosi, target_nrst}, pins[4:2]);
				end
				step_cycle();
			end
		end
		finish_test("target routing");

		$display("Tests run %0d, failed %0d, checks compared %0d", tests_run, tests_failed,
			checks_done);
		if (tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- list.f
src/cw_reg_pkg.sv
src/cw_target_pkg.sv
src/usb_reg_bridge.sv
src/reg_trigger.sv
src/reg_glitch.sv
src/reg_target_io.sv
src/cw_lite_top.sv
test/tb_clock_gen.sv
test/cw_lite_tb.sv

//--- Bender.yml
package:
  name: cw_lite

sources:
  - src/cw_reg_pkg.sv
  - src/cw_target_pkg.sv
  - src/usb_reg_bridge.sv
  - src/reg_trigger.sv
  - src/reg_glitch.sv
  - src/reg_target_io.sv
  - src/cw_lite_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/cw_lite_tb.sv
